// File: hw/arp_macros.svh
`ifndef ARP_MACROS_SVH
`define ARP_MACROS_SVH

// arp opcodes
`define ARP_OPER_REQUEST 16'h0001
`define ARP_OPER_REPLY 16'h0002

// ether type and arp hardware/protocol types
`define ETH_TYPE_ARP 16'h0806
`define ARP_HTYPE_ETH 16'h0001
`define ARP_PTYPE_IPV4 16'h0800

`define MAC_BROADCAST 48'hffff_ffff_ffff
`define MAC_ZERO 48'h0000_0000_0000

// 16 rows, indexed by low ip bits
`define ARP_CACHE_ADDR_WIDTH 4

// request frames in total, and cycle counts between them
`define ARP_RETRY_COUNT 4
`define ARP_RETRY_INTERVAL 40
`define ARP_REQUEST_TIMEOUT 120

`endif

// File: hw/arp_pkg.sv
`include "arp_macros.svh"

package arp_pkg;

    typedef logic [47:0] mac_t;
    typedef logic [31:0] ip_t;
    typedef logic [15:0] arp_oper_t;
    typedef logic [15:0] eth_type_t;

    // row index into the cache, low bits of the ip
    typedef logic [`ARP_CACHE_ADDR_WIDTH-1:0] cache_idx_t;

    // lookup sequencing
    typedef enum logic [2:0] {
        LK_IDLE,
        LK_QUERY,
        LK_SEND,
        LK_RESOLVE,
        LK_RESPOND
    } lookup_state_t;

endpackage

// File: hw/arp_cache.sv
`include "arp_macros.svh"

module arp_cache (
    input  logic          clk,
    input  logic          rst,
    input  logic          query_valid,
    input  arp_pkg::ip_t  query_ip,
    output logic          hit_valid,
    output logic          hit,
    output arp_pkg::mac_t hit_mac,
    input  logic          learn_valid,
    input  arp_pkg::ip_t  learn_ip,
    input  arp_pkg::mac_t learn_mac,
    input  logic          clear_cache
);
    import arp_pkg::*;

    localparam int ROWS = 1 << `ARP_CACHE_ADDR_WIDTH;

    logic [ROWS-1:0] row_valid;
    ip_t             tag_mem [ROWS];
    mac_t            mac_mem [ROWS];
    cache_idx_t      query_idx;
    cache_idx_t      learn_idx;

    assign query_idx = query_ip[`ARP_CACHE_ADDR_WIDTH-1:0];
    assign learn_idx = learn_ip[`ARP_CACHE_ADDR_WIDTH-1:0];

    // valid bits and the query response strobe
    always_ff @(posedge clk) begin
        if (rst) begin
            row_valid <= '0;
            hit_valid <= 1'b0;
            hit       <= 1'b0;
        end else begin
            hit_valid <= query_valid;
            hit       <= row_valid[query_idx] && (tag_mem[query_idx] == query_ip);
            if (clear_cache) begin
                row_valid <= '0;
            end else if (learn_valid) begin
                row_valid[learn_idx] <= 1'b1;
            end
        end
    end

    // tag and mac storage, overwrite by index
    always_ff @(posedge clk) begin
        if (learn_valid) begin
            tag_mem[learn_idx] <= learn_ip;
            mac_mem[learn_idx] <= learn_mac;
        end
        hit_mac <= mac_mem[query_idx];
    end

endmodule

// File: hw/arp_retry_timer.sv
`include "arp_macros.svh"

module arp_retry_timer (
    input  logic clk,
    input  logic rst,
    input  logic start,
    input  logic stop,
    output logic retry,
    output logic expired
);

    localparam int TIMER_MAX = (`ARP_REQUEST_TIMEOUT > `ARP_RETRY_INTERVAL) ?
                               `ARP_REQUEST_TIMEOUT : `ARP_RETRY_INTERVAL;
    localparam int TIMER_W = $clog2(TIMER_MAX + 1);
    localparam int CNT_W = $clog2(`ARP_RETRY_COUNT + 1);

    logic               active;
    logic [CNT_W-1:0]   retry_cnt;
    logic [TIMER_W-1:0] timer;

    always_ff @(posedge clk) begin
        if (rst) begin
            active    <= 1'b0;
            retry_cnt <= '0;
            timer     <= '0;
            retry     <= 1'b0;
            expired   <= 1'b0;
        end else begin
            retry   <= 1'b0;
            expired <= 1'b0;
            if (start) begin
                // first frame already went out
                active    <= 1'b1;
                retry_cnt <= CNT_W'(`ARP_RETRY_COUNT - 1);
                timer     <= TIMER_W'(`ARP_RETRY_INTERVAL);
            end else if (stop) begin
                active <= 1'b0;
            end else if (active) begin
                if (timer != '0) begin
                    timer <= timer - 1'b1;
                end else if (retry_cnt != '0) begin
                    retry     <= 1'b1;
                    retry_cnt <= retry_cnt - 1'b1;
                    // last retry waits the full timeout
                    timer <= (retry_cnt > CNT_W'(1)) ? TIMER_W'(`ARP_RETRY_INTERVAL) :
                                                       TIMER_W'(`ARP_REQUEST_TIMEOUT);
                end else begin
                    expired <= 1'b1;
                    active  <= 1'b0;
                end
            end
        end
    end

endmodule

// File: hw/arp_lookup_fsm.sv
`include "arp_macros.svh"

module arp_lookup_fsm (
    input  logic          clk,
    input  logic          rst,
    input  logic          req_valid,
    output logic          req_ready,
    input  arp_pkg::ip_t  req_ip,
    output logic          resp_valid,
    input  logic          resp_ready,
    output logic          resp_error,
    output arp_pkg::mac_t resp_mac,
    input  arp_pkg::ip_t  gateway_ip,
    input  arp_pkg::ip_t  subnet_mask,
    output logic          query_valid,
    output arp_pkg::ip_t  query_ip,
    input  logic          hit_valid,
    input  logic          hit,
    input  arp_pkg::mac_t hit_mac,
    output logic          send_req,
    output arp_pkg::ip_t  send_ip,
    input  logic          send_ack,
    output logic          start,
    output logic          stop,
    input  logic          retry,
    input  logic          expired
);
    import arp_pkg::*;

    lookup_state_t state;
    ip_t           target_ip;
    logic          first_send;
    logic          accept;
    logic          is_bcast;
    logic          on_subnet;

    assign accept = req_valid & req_ready;
    // all host bits set
    assign is_bcast = ~(req_ip | subnet_mask) == '0;
    // no network bits differ from the gateway
    assign on_subnet = ((req_ip ^ gateway_ip) & subnet_mask) == '0;

    assign query_ip = target_ip;
    assign send_ip  = target_ip;
    assign send_req = (state == LK_SEND);
    assign start    = send_req & send_ack & first_send;
    assign stop     = (state == LK_RESOLVE) & hit_valid & hit;

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= LK_IDLE;
            req_ready   <= 1'b0;
            resp_valid  <= 1'b0;
            query_valid <= 1'b0;
            first_send  <= 1'b0;
        end else begin
            case (state)
                LK_IDLE: begin
                    req_ready <= ~accept;
                    if (accept && is_bcast) begin
                        resp_valid <= 1'b1;
                        resp_error <= 1'b0;
                        resp_mac   <= `MAC_BROADCAST;
                        state      <= LK_RESPOND;
                    end else if (accept) begin
                        // off-subnet targets resolve through the gateway
                        target_ip   <= on_subnet ? req_ip : gateway_ip;
                        query_valid <= 1'b1;
                        state       <= LK_QUERY;
                    end
                end
                LK_QUERY: begin
                    query_valid <= 1'b0;
                    if (hit_valid && hit) begin
                        resp_valid <= 1'b1;
                        resp_error <= 1'b0;
                        resp_mac   <= hit_mac;
                        state      <= LK_RESPOND;
                    end else if (hit_valid) begin
                        first_send <= 1'b1;
                        state      <= LK_SEND;
                    end
                end
                LK_SEND: begin
                    if (expired) begin
                        resp_valid <= 1'b1;
                        resp_error <= 1'b1;
                        resp_mac   <= `MAC_ZERO;
                        state      <= LK_RESPOND;
                    end else if (send_ack) begin
                        first_send <= 1'b0;
                        state      <= LK_RESOLVE;
                    end
                end
                LK_RESOLVE: begin
                    // re-query on alternate cycles, a reply lands in the cache
                    query_valid <= ~query_valid;
                    if (hit_valid && hit) begin
                        query_valid <= 1'b0;
                        resp_valid  <= 1'b1;
                        resp_error  <= 1'b0;
                        resp_mac    <= hit_mac;
                        state       <= LK_RESPOND;
                    end else if (expired) begin
                        query_valid <= 1'b0;
                        resp_valid  <= 1'b1;
                        resp_error  <= 1'b1;
                        resp_mac    <= `MAC_ZERO;
                        state       <= LK_RESPOND;
                    end else if (retry) begin
                        query_valid <= 1'b0;
                        state       <= LK_SEND;
                    end
                end
                LK_RESPOND: begin
                    if (resp_ready) begin
                        resp_valid <= 1'b0;
                        req_ready  <= 1'b1;
                        state      <= LK_IDLE;
                    end
                end
                default: begin
                    state <= LK_IDLE;
                end
            endcase
        end
    end

endmodule

// File: hw/arp_frame_io.sv
`include "arp_macros.svh"

module arp_frame_io (
    input  logic                clk,
    input  logic                rst,
    input  logic                in_valid,
    output logic                in_ready,
    input  arp_pkg::mac_t       in_eth_src_mac,
    input  arp_pkg::eth_type_t  in_eth_type,
    input  arp_pkg::eth_type_t  in_htype,
    input  arp_pkg::eth_type_t  in_ptype,
    input  arp_pkg::arp_oper_t  in_oper,
    input  arp_pkg::mac_t       in_sha,
    input  arp_pkg::ip_t        in_spa,
    input  arp_pkg::mac_t       in_tha,
    input  arp_pkg::ip_t        in_tpa,
    output logic                out_valid,
    input  logic                out_ready,
    output arp_pkg::mac_t       out_eth_dest_mac,
    output arp_pkg::arp_oper_t  out_oper,
    output arp_pkg::mac_t       out_tha,
    output arp_pkg::ip_t        out_tpa,
    input  arp_pkg::ip_t        local_ip,
    output logic                learn_valid,
    output arp_pkg::ip_t        learn_ip,
    output arp_pkg::mac_t       learn_mac,
    input  logic                send_req,
    input  arp_pkg::ip_t        send_ip,
    output logic                send_ack
);

    logic ports_open;
    logic slot_free;
    logic accept;
    logic arp_hdr_ok;
    logic want_reply;

    assign slot_free = ~out_valid | out_ready;
    // pending request frame wins the slot
    assign in_ready  = ports_open & slot_free & ~send_req;
    assign send_ack  = send_req & slot_free;
    assign accept    = in_valid & in_ready;

    assign arp_hdr_ok = (in_eth_type == `ETH_TYPE_ARP) && (in_htype == `ARP_HTYPE_ETH) &&
                        (in_ptype == `ARP_PTYPE_IPV4);
    // target hardware address is unknown in a request, only tpa selects us
    assign want_reply = arp_hdr_ok && (in_oper == `ARP_OPER_REQUEST) && (in_tpa == local_ip);

    always_ff @(posedge clk) begin
        if (rst) begin
            ports_open  <= 1'b0;
            learn_valid <= 1'b0;
            out_valid   <= 1'b0;
        end else begin
            ports_open  <= 1'b1;
            learn_valid <= accept & arp_hdr_ok;
            if (send_ack || (accept && want_reply)) begin
                out_valid <= 1'b1;
            end else if (out_ready) begin
                out_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            learn_ip  <= in_spa;
            learn_mac <= in_sha;
        end
        if (send_ack) begin
            // broadcast who-has
            out_eth_dest_mac <= `MAC_BROADCAST;
            out_oper         <= `ARP_OPER_REQUEST;
            out_tha          <= `MAC_ZERO;
            out_tpa          <= send_ip;
        end else if (accept && want_reply) begin
            out_eth_dest_mac <= in_eth_src_mac;
            out_oper         <= `ARP_OPER_REPLY;
            out_tha          <= in_sha;
            out_tpa          <= in_spa;
        end
    end

endmodule

// File: hw/arp_top.sv
module arp_top (
    input  logic               clk,
    input  logic               rst,
    input  logic               in_valid,
    output logic               in_ready,
    input  arp_pkg::mac_t      in_eth_src_mac,
    input  arp_pkg::eth_type_t in_eth_type,
    input  arp_pkg::eth_type_t in_htype,
    input  arp_pkg::eth_type_t in_ptype,
    input  arp_pkg::arp_oper_t in_oper,
    input  arp_pkg::mac_t      in_sha,
    input  arp_pkg::ip_t       in_spa,
    input  arp_pkg::mac_t      in_tha,
    input  arp_pkg::ip_t       in_tpa,
    output logic               out_valid,
    input  logic               out_ready,
    output arp_pkg::mac_t      out_eth_dest_mac,
    output arp_pkg::arp_oper_t out_oper,
    output arp_pkg::mac_t      out_tha,
    output arp_pkg::ip_t       out_tpa,
    input  logic               req_valid,
    output logic               req_ready,
    input  arp_pkg::ip_t       req_ip,
    output logic               resp_valid,
    input  logic               resp_ready,
    output logic               resp_error,
    output arp_pkg::mac_t      resp_mac,
    // the consumer fills the fixed source fields from local_mac
    input  arp_pkg::mac_t      local_mac,
    input  arp_pkg::ip_t       local_ip,
    input  arp_pkg::ip_t       gateway_ip,
    input  arp_pkg::ip_t       subnet_mask,
    input  logic               clear_cache
);
    import arp_pkg::*;

    logic learn_valid;
    ip_t  learn_ip;
    mac_t learn_mac;
    logic query_valid;
    ip_t  query_ip;
    logic hit_valid;
    logic hit;
    mac_t hit_mac;
    logic send_req;
    ip_t  send_ip;
    logic send_ack;
    logic timer_start;
    logic timer_stop;
    logic timer_retry;
    logic timer_expired;

    arp_frame_io frame_io0 (
        .clk(clk), .rst(rst),
        .in_valid(in_valid), .in_ready(in_ready), .in_eth_src_mac(in_eth_src_mac),
        .in_eth_type(in_eth_type), .in_htype(in_htype), .in_ptype(in_ptype),
        .in_oper(in_oper), .in_sha(in_sha), .in_spa(in_spa), .in_tha(in_tha), .in_tpa(in_tpa),
        .out_valid(out_valid), .out_ready(out_ready), .out_eth_dest_mac(out_eth_dest_mac),
        .out_oper(out_oper), .out_tha(out_tha), .out_tpa(out_tpa),
        .local_ip(local_ip),
        .learn_valid(learn_valid), .learn_ip(learn_ip), .learn_mac(learn_mac),
        .send_req(send_req), .send_ip(send_ip), .send_ack(send_ack)
    );

    arp_cache cache0 (
        .clk(clk), .rst(rst),
        .query_valid(query_valid), .query_ip(query_ip),
        .hit_valid(hit_valid), .hit(hit), .hit_mac(hit_mac),
        .learn_valid(learn_valid), .learn_ip(learn_ip), .learn_mac(learn_mac),
        .clear_cache(clear_cache)
    );

    arp_lookup_fsm lookup0 (
        .clk(clk), .rst(rst),
        .req_valid(req_valid), .req_ready(req_ready), .req_ip(req_ip),
        .resp_valid(resp_valid), .resp_ready(resp_ready), .resp_error(resp_error),
        .resp_mac(resp_mac), .gateway_ip(gateway_ip), .subnet_mask(subnet_mask),
        .query_valid(query_valid), .query_ip(query_ip),
        .hit_valid(hit_valid), .hit(hit), .hit_mac(hit_mac),
        .send_req(send_req), .send_ip(send_ip), .send_ack(send_ack),
        .start(timer_start), .stop(timer_stop), .retry(timer_retry), .expired(timer_expired)
    );

    arp_retry_timer timer0 (
        .clk(clk), .rst(rst),
        .start(timer_start), .stop(timer_stop),
        .retry(timer_retry), .expired(timer_expired)
    );

endmodule

// File: sim/arp_tb.sv
`include "arp_macros.svh"

module arp_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import arp_pkg::*;

    localparam ip_t LOCAL_IP    = 32'h0a00_0001;
    localparam ip_t GATEWAY_IP  = 32'h0a00_00fe;
    localparam ip_t SUBNET_MASK = 32'hffff_ff00;
    // four full retry schedules plus slack for the short tests
    localparam int TIMEOUT_CYCLES =
        ((`ARP_RETRY_COUNT - 1) * `ARP_RETRY_INTERVAL + `ARP_REQUEST_TIMEOUT) * 4 + 2000;

    logic      clk;
    logic      rst;
    logic      in_valid;
    logic      in_ready;
    mac_t      in_eth_src_mac;
    eth_type_t in_eth_type;
    eth_type_t in_htype;
    eth_type_t in_ptype;
    arp_oper_t in_oper;
    mac_t      in_sha;
    ip_t       in_spa;
    mac_t      in_tha;
    ip_t       in_tpa;
    logic      out_valid;
    logic      out_ready;
    mac_t      out_eth_dest_mac;
    arp_oper_t out_oper;
    mac_t      out_tha;
    ip_t       out_tpa;
    logic      req_valid;
    logic      req_ready;
    ip_t       req_ip;
    logic      resp_valid;
    logic      resp_ready;
    logic      resp_error;
    mac_t      resp_mac;
    mac_t      local_mac;
    ip_t       local_ip;
    ip_t       gateway_ip;
    ip_t       subnet_mask;
    logic      clear_cache;

    int   errors;
    int   checks;
    int   cycles;
    ip_t  learned_ip;

    arp_top dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic check_mac(string what, mac_t got, mac_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t ns: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_ip(string what, ip_t got, ip_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t ns: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_oper(string what, arp_oper_t got, arp_oper_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t ns: %s got %0d expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_bit(string what, logic got, logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t ns: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    // unicast mac, locally administered
    function automatic mac_t rand_mac();
        mac_t m;
        m = {16'($urandom), $urandom};
        m[40] = 1'b0;
        m[41] = 1'b1;
        return m;
    endfunction

    // on-subnet host with a chosen cache row
    function automatic ip_t host_ip(logic [3:0] row);
        logic [3:0] high;
        high = 4'($urandom_range(15, 0));
        return {8'd10, 8'd0, 8'd0, high, row};
    endfunction

    task automatic send_frame(arp_oper_t oper, mac_t sha, ip_t spa, mac_t tha, ip_t tpa);
        @(negedge clk);
        in_eth_src_mac = sha;
        in_eth_type    = `ETH_TYPE_ARP;
        in_htype       = `ARP_HTYPE_ETH;
        in_ptype       = `ARP_PTYPE_IPV4;
        in_oper        = oper;
        in_sha         = sha;
        in_spa         = spa;
        in_tha         = tha;
        in_tpa         = tpa;
        in_valid       = 1'b1;
        while (!in_ready) @(negedge clk);
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    task automatic take_frame(output mac_t dest, output arp_oper_t oper, output mac_t tha,
                              output ip_t tpa);
        @(negedge clk);
        while (!out_valid) @(negedge clk);
        dest      = out_eth_dest_mac;
        oper      = out_oper;
        tha       = out_tha;
        tpa       = out_tpa;
        out_ready = 1'b1;
        @(negedge clk);
        out_ready = 1'b0;
    endtask

    task automatic expect_request(ip_t exp_tpa);
        mac_t      dest;
        arp_oper_t oper;
        mac_t      tha;
        ip_t       tpa;
        take_frame(dest, oper, tha, tpa);
        check_mac("request dest mac", dest, `MAC_BROADCAST);
        check_oper("request oper", oper, `ARP_OPER_REQUEST);
        check_mac("request tha", tha, `MAC_ZERO);
        check_ip("request tpa", tpa, exp_tpa);
    endtask

    task automatic lookup_ip(ip_t ip);
        @(negedge clk);
        req_ip    = ip;
        req_valid = 1'b1;
        while (!req_ready) @(negedge clk);
        @(negedge clk);
        req_valid = 1'b0;
    endtask

    task automatic get_response(output logic err, output mac_t mac);
        @(negedge clk);
        while (!resp_valid) @(negedge clk);
        err        = resp_error;
        mac        = resp_mac;
        resp_ready = 1'b1;
        @(negedge clk);
        resp_ready = 1'b0;
    endtask

    task automatic expect_response(string what, logic exp_err, mac_t exp_mac);
        logic err;
        mac_t mac;
        get_response(err, mac);
        check_bit({what, " error"}, err, exp_err);
        check_mac({what, " mac"}, mac, exp_mac);
    endtask

    // handshake outputs stay low while reset is held
    task automatic test_reset_state();
        check_bit("in_ready in reset", in_ready, 1'b0);
        check_bit("out_valid in reset", out_valid, 1'b0);
        check_bit("req_ready in reset", req_ready, 1'b0);
        check_bit("resp_valid in reset", resp_valid, 1'b0);
    endtask

    task automatic test_reply();
        mac_t      sha;
        ip_t       spa;
        mac_t      dest;
        arp_oper_t oper;
        mac_t      tha;
        ip_t       tpa;
        sha = rand_mac();
        spa = host_ip(4'h7);
        send_frame(`ARP_OPER_REQUEST, sha, spa, `MAC_ZERO, LOCAL_IP);
        take_frame(dest, oper, tha, tpa);
        check_mac("reply dest mac", dest, sha);
        check_oper("reply oper", oper, `ARP_OPER_REPLY);
        check_mac("reply tha", tha, sha);
        check_ip("reply tpa", tpa, spa);
        // who-has for some other host
        send_frame(`ARP_OPER_REQUEST, rand_mac(), host_ip(4'h8), `MAC_ZERO, 32'h0a00_0009);
        repeat (10) begin
            @(negedge clk);
            check_bit("out_valid for foreign target", out_valid, 1'b0);
        end
    endtask

    task automatic test_learn_hit();
        mac_t sha;
        sha        = rand_mac();
        learned_ip = host_ip(4'h2);
        send_frame(`ARP_OPER_REPLY, sha, learned_ip, local_mac, LOCAL_IP);
        lookup_ip(learned_ip);
        expect_response("learned hit", 1'b0, sha);
        check_bit("out_valid after hit", out_valid, 1'b0);
    endtask

    task automatic test_broadcast();
        lookup_ip(32'h0a00_00ff);
        expect_response("subnet broadcast", 1'b0, `MAC_BROADCAST);
    endtask

    task automatic test_miss_resolved();
        ip_t  target;
        mac_t mac;
        target = host_ip(4'h3);
        mac    = rand_mac();
        lookup_ip(target);
        expect_request(target);
        send_frame(`ARP_OPER_REPLY, mac, target, local_mac, LOCAL_IP);
        expect_response("on-subnet resolve", 1'b0, mac);
        // off-subnet, resolved through the gateway
        target = {8'd172, 8'd16, 8'($urandom), 8'd20};
        mac    = rand_mac();
        lookup_ip(target);
        expect_request(GATEWAY_IP);
        send_frame(`ARP_OPER_REPLY, mac, GATEWAY_IP, local_mac, LOCAL_IP);
        expect_response("gateway resolve", 1'b0, mac);
    endtask

    task automatic test_timeout();
        ip_t  target;
        int   frames;
        logic err;
        mac_t mac;
        target = host_ip(4'h5);
        frames = 0;
        lookup_ip(target);
        while (!resp_valid) begin
            if (out_valid) begin
                frames++;
                check_ip("retry tpa", out_tpa, target);
                out_ready = 1'b1;
            end else begin
                out_ready = 1'b0;
            end
            @(negedge clk);
        end
        out_ready = 1'b0;
        checks++;
        if (frames != `ARP_RETRY_COUNT) begin
            errors++;
            $display("mismatch at %0t ns: request frames got %0d expected %0d", $time, frames,
                     `ARP_RETRY_COUNT);
        end
        get_response(err, mac);
        check_bit("timeout error", err, 1'b1);
    endtask

    task automatic test_clear();
        mac_t mac;
        @(negedge clk);
        clear_cache = 1'b1;
        @(negedge clk);
        clear_cache = 1'b0;
        lookup_ip(learned_ip);
        expect_request(learned_ip);
        mac = rand_mac();
        send_frame(`ARP_OPER_REPLY, mac, learned_ip, local_mac, LOCAL_IP);
        expect_response("relearn after clear", 1'b0, mac);
    endtask

    initial begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout after %0d cycles, a handshake never completed", cycles);
        $display("checks %0d, errors %0d", checks, errors);
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin
        void'($urandom(56));
        errors         = 0;
        checks         = 0;
        rst            = 1'b1;
        in_valid       = 1'b0;
        in_eth_src_mac = '0;
        in_eth_type    = '0;
        in_htype       = '0;
        in_ptype       = '0;
        in_oper        = '0;
        in_sha         = '0;
        in_spa         = '0;
        in_tha         = '0;
        in_tpa         = '0;
        out_ready      = 1'b0;
        req_valid      = 1'b0;
        req_ip         = '0;
        resp_ready     = 1'b0;
        local_mac      = 48'h0200_0000_0001;
        local_ip       = LOCAL_IP;
        gateway_ip     = GATEWAY_IP;
        subnet_mask    = SUBNET_MASK;
        clear_cache    = 1'b0;
        repeat (16) @(negedge clk);
        test_reset_state();
        rst = 1'b0;
        repeat (2) @(negedge clk);
        test_reply();
        test_learn_hit();
        test_broadcast();
        test_miss_resolved();
        test_timeout();
        test_clear();
        repeat (4) @(negedge clk);
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// File: tb.f
+incdir+hw
hw/arp_pkg.sv
hw/arp_cache.sv
hw/arp_retry_timer.sv
hw/arp_lookup_fsm.sv
hw/arp_frame_io.sv
hw/arp_top.sv
sim/arp_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the arp engine testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps -f tb.f --top-module arp_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/Varp_tb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "ALL CHECKS PASSED"; then
    exit 0
fi
exit 1
